// File: filelist.f
+incdir+source
source/csr_pkg.sv
source/csr_write_value.sv
source/csr_trap_ctrl.sv
source/csr_regfile.sv
source/csr_top.sv
bench/csr_asserts.sv
bench/csr_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/csr_tb.sv
`timescale 1ns/1ps

`include "csr_config.svh"

module csr_tb;

    import csr_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_INSTR       = 57;                    // Instructions issued by the sequence
    localparam int WATCHDOG_CYCLES = NUM_INSTR * 4 + 50;

    logic       clk;
    logic       rst_n;
    logic       stage_en;
    logic       is_system;
    logic       is_illegal;
    logic       is_ecall;
    logic       is_ebreak;
    logic       is_mret;
    logic       ext_irq;
    logic       sw_irq;
    csr_op_e    funct3;
    csr_addr_e  csr_index;
    csr_data_t  rs1;
    csr_data_t  imm;
    csr_data_t  pc;
    csr_data_t  csr_out;
    csr_data_t  trap_address;
    csr_data_t  return_address;
    logic       go_to_trap_q;
    logic       return_from_trap_q;

    logic [31:0] rng = 32'd29;      // xorshift state
    csr_data_t   m_mscratch;        // Reference model
    csr_data_t   m_mie;
    csr_data_t   m_mepc;
    csr_data_t   m_mcause;
    logic        m_status_mie;
    logic        m_status_mpie;
    csr_data_t   r;
    csr_data_t   i;
    csr_data_t   p;
    csr_data_t   v;
    csr_data_t   first;

    csr_top dut (
        .i_clk                (clk),
        .i_rst_n              (rst_n),
        .i_stage_en           (stage_en),
        .i_is_system          (is_system),
        .i_funct3             (funct3),
        .i_csr_index          (csr_index),
        .i_rs1                (rs1),
        .i_imm                (imm),
        .i_pc                 (pc),
        .i_is_illegal         (is_illegal),
        .i_is_ecall           (is_ecall),
        .i_is_ebreak          (is_ebreak),
        .i_is_mret            (is_mret),
        .i_ext_irq            (ext_irq),
        .i_sw_irq             (sw_irq),
        .o_csr_out            (csr_out),
        .o_trap_address       (trap_address),
        .o_return_address     (return_address),
        .o_go_to_trap_q       (go_to_trap_q),
        .o_return_from_trap_q (return_from_trap_q)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic csr_data_t rand_word();
        rng = rng ^ (rng << 13);        // xorshift32
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Expected new CSR value for each funct3
    function automatic csr_data_t apply_op(csr_op_e op, csr_data_t old, csr_data_t s,
                                           csr_data_t u);
        case (op)
            CSRRW:   return s;
            CSRRS:   return old | s;
            CSRRC:   return old & ~s;
            CSRRWI:  return u;
            CSRRSI:  return old | u;
            CSRRCI:  return old & ~u;
            default: return old;
        endcase
    endfunction

    function automatic csr_data_t mstatus_model();
        return 32'h1800 | (csr_data_t'(m_status_mpie) << 7) | (csr_data_t'(m_status_mie) << 3);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string name, input csr_data_t got, input csr_data_t exp);
        assert (got === exp) else begin
            abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Holds stage enable for one clock and idles the inputs after it
    task automatic step();
        stage_en = 1'b1;
        @(posedge clk);
        @(negedge clk);
        stage_en   = 1'b0;
        is_system  = 1'b0;
        funct3     = CSR_NONE;
        {is_illegal, is_ecall, is_ebreak, is_mret} = 4'b0000;
    endtask

    task automatic csr_op(input csr_op_e op, input csr_addr_e addr, input csr_data_t s,
                          input csr_data_t u, output csr_data_t old);
        is_system = 1'b1;
        funct3    = op;
        csr_index = addr;
        rs1       = s;
        imm       = u;
        step();
        old = csr_out;                  // Value before the write
    endtask

    task automatic csr_read(input csr_addr_e addr, output csr_data_t got);
        csr_op(CSRRS, addr, 0, 0, got);     // Set with zero source
    endtask

    task automatic check_read(input string name, input csr_addr_e addr, input csr_data_t exp);
        csr_data_t got;
        csr_read(addr, got);
        check_equal({"o_csr_out for ", name}, got, exp);
    endtask

    task automatic issue_reads(input int count);
        csr_data_t unused;
        repeat (count) begin
            csr_read(ADDR_MSCRATCH, unused);
        end
    endtask

    // Flag bits in order illegal, ecall, ebreak, mret
    task automatic sys_event(input csr_data_t at_pc, input logic [3:0] flags);
        is_system = 1'b1;
        pc        = at_pc;
        {is_illegal, is_ecall, is_ebreak, is_mret} = flags;
        step();
    endtask

    task automatic expect_trap(input csr_data_t at_pc, input csr_data_t cause);
        m_mepc        = at_pc;
        m_mcause      = cause;
        m_status_mpie = m_status_mie;   // Enable stacked
        m_status_mie  = 1'b0;
        check_equal("o_go_to_trap_q", go_to_trap_q, 1);
        check_equal("o_return_address", return_address, m_mepc);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("Timeout: the test sequence did not finish in time");
    end

    initial begin
        csr_op_e ops [0:5];
        ops = '{CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};
        rst_n     = 1'b0;
        stage_en  = 1'b0;
        is_system = 1'b0;
        {is_illegal, is_ecall, is_ebreak, is_mret} = 4'b0000;
        {ext_irq, sw_irq} = 2'b00;
        funct3    = CSR_NONE;
        csr_index = ADDR_MSCRATCH;
        {rs1, imm, pc} = '0;
        {m_mscratch, m_mie, m_mepc, m_mcause} = '0;
        {m_status_mie, m_status_mpie} = 2'b00;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_equal("o_csr_out", csr_out, 0);
        check_equal("o_trap_address", trap_address, `CSR_TRAP_VECTOR);

        for (int k = 0; k < 6; k++) begin      // All six ops on mscratch
            r = rand_word();
            i = rand_word() & 32'h1F;           // uimm is 5 bits
            csr_op(ops[k], ADDR_MSCRATCH, r, i, v);
            check_equal("o_csr_out", v, m_mscratch);
            m_mscratch = apply_op(ops[k], m_mscratch, r, i);
        end
        check_read("mscratch", ADDR_MSCRATCH, m_mscratch);

        r = rand_word();
        csr_op(CSRRW, ADDR_MSTATUS, r, 0, v);
        {m_status_mpie, m_status_mie} = {r[7], r[3]};
        check_read("mstatus", ADDR_MSTATUS, mstatus_model());
        r = rand_word();
        csr_op(CSRRW, ADDR_MIE, r, 0, v);
        m_mie = r & 32'h808;                    // meie and msie only
        check_read("mie", ADDR_MIE, m_mie);
        check_read("misa", ADDR_MISA, 32'h4000_0100);
        check_read("mvendorid", ADDR_MVENDORID, 0);
        check_read("marchid", ADDR_MARCHID, 0);
        check_read("mimpid", ADDR_MIMPID, 0);
        check_read("mhartid", ADDR_MHARTID, 0);

        r = rand_word() & ~32'h3;               // Direct mode
        csr_op(CSRRW, ADDR_MTVEC, r, 0, v);
        check_equal("o_trap_address", trap_address, r);
        csr_op(CSRRW, ADDR_MSTATUS, 32'h8, 0, v);
        {m_status_mpie, m_status_mie} = 2'b01;
        p = rand_word() & ~32'h3;
        sys_event(p, 4'b0100);                  // ecall
        expect_trap(p, 32'd11);
        check_read("mcause", ADDR_MCAUSE, m_mcause);
        check_read("mstatus", ADDR_MSTATUS, mstatus_model());

        p = rand_word() & ~32'h3;
        sys_event(p, 4'b1100);                  // Illegal wins over ecall
        expect_trap(p, 32'd2);
        check_read("mcause", ADDR_MCAUSE, m_mcause);
        csr_op(CSRRW, ADDR_MIE, 32'h808, 0, v);
        m_mie = 32'h808;
        {ext_irq, sw_irq} = 2'b11;
        @(negedge clk);                         // mip picks up the levels
        check_read("mip", ADDR_MIP, 32'h808);
        check_equal("o_go_to_trap_q", go_to_trap_q, 0);     // Global enable still clear
        csr_op(CSRRW, ADDR_MSTATUS, 32'h8, 0, v);
        {m_status_mpie, m_status_mie} = 2'b01;
        check_equal("o_go_to_trap_q", go_to_trap_q, 0);
        p = rand_word() & ~32'h3;
        sys_event(p, 4'b0000);                  // Both interrupts pending
        expect_trap(p, 32'h8000_000B);
        {ext_irq, sw_irq} = 2'b00;
        check_read("mcause", ADDR_MCAUSE, m_mcause);

        p = rand_word() & ~32'h3;
        sys_event(p, 4'b1001);                  // Illegal with mret traps
        expect_trap(p, 32'd2);
        check_equal("o_return_from_trap_q", return_from_trap_q, 0);

        sys_event(rand_word() & ~32'h3, 4'b0001);   // mret with mpie clear
        check_equal("o_return_from_trap_q", return_from_trap_q, 1);
        check_equal("o_go_to_trap_q", go_to_trap_q, 0);
        {m_status_mpie, m_status_mie} = {1'b1, m_status_mpie};
        check_read("mstatus", ADDR_MSTATUS, mstatus_model());

        sys_event(rand_word() & ~32'h3, 4'b0001);   // mret with mpie set
        check_equal("o_return_from_trap_q", return_from_trap_q, 1);
        check_equal("o_go_to_trap_q", go_to_trap_q, 0);
        {m_status_mpie, m_status_mie} = {1'b1, m_status_mpie};
        check_read("mstatus", ADDR_MSTATUS, mstatus_model());

        csr_read(ADDR_MCYCLE, first);           // Read edge itself holds the count
        issue_reads(5);
        check_read("mcycle", ADDR_MCYCLE, first + 5);
        csr_op(CSRRWI, ADDR_MCOUNTINHIBIT, 0, 1, v);
        csr_read(ADDR_MCYCLE, first);
        issue_reads(5);
        check_read("mcycle", ADDR_MCYCLE, first);   // Frozen
        r = rand_word() & 32'h7FFF_FFFF;        // No carry into mcycleh
        csr_op(CSRRW, ADDR_MCYCLE, r, 0, v);
        check_read("mcycle", ADDR_MCYCLE, r);
        csr_op(CSRRWI, ADDR_MCOUNTINHIBIT, 0, 0, v);
        issue_reads(5);
        check_read("mcycle", ADDR_MCYCLE, r + 5);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: bench/csr_asserts.sv
`timescale 1ns/1ps

module csr_asserts (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  csr_pkg::csr_data_t  i_pc,                   // pc seen by the CSR stage
    input  csr_pkg::csr_data_t  i_return_address,       // mepc
    input  logic                i_go_to_trap_q,
    input  logic                i_return_from_trap_q
);

    // Trap pulse drops after one clock
    trap_pulse_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_go_to_trap_q |=> !i_go_to_trap_q)
        else $error("trap pulse lasted more than one cycle");

    // Return pulse drops after one clock
    return_pulse_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_return_from_trap_q |=> !i_return_from_trap_q)
        else $error("return pulse lasted more than one cycle");

    pulses_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_go_to_trap_q && i_return_from_trap_q))
        else $error("trap and return pulses high together");

    // mepc already loaded when the pulse is seen
    trap_saves_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_go_to_trap_q) |-> (i_return_address == $past(i_pc)))
        else $error("mepc does not hold the trapping pc");

    // Mid-cycle sample, flops already cleared by the async reset
    quiet_in_reset: assert property (@(negedge i_clk)
        !i_rst_n |-> !(i_go_to_trap_q || i_return_from_trap_q))
        else $error("pulse high while reset is asserted");

endmodule

bind csr_top csr_asserts u_asserts (
    .i_clk                (i_clk),
    .i_rst_n              (i_rst_n),
    .i_pc                 (i_pc),
    .i_return_address     (o_return_address),
    .i_go_to_trap_q       (o_go_to_trap_q),
    .i_return_from_trap_q (o_return_from_trap_q)
);

// File: source/csr_top.sv
`timescale 1ns/1ps

module csr_top (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_stage_en,             // Instruction in CSR stage
    input  logic                i_is_system,            // SYSTEM opcode
    input  csr_pkg::csr_op_e    i_funct3,               // CSR operation
    input  csr_pkg::csr_addr_e  i_csr_index,            // CSR address
    input  csr_pkg::csr_data_t  i_rs1,
    input  csr_pkg::csr_data_t  i_imm,
    input  csr_pkg::csr_data_t  i_pc,
    input  logic                i_is_illegal,
    input  logic                i_is_ecall,
    input  logic                i_is_ebreak,
    input  logic                i_is_mret,
    input  logic                i_ext_irq,              // Level
    input  logic                i_sw_irq,               // Level
    output csr_pkg::csr_data_t  o_csr_out,              // Old CSR value for rd
    output csr_pkg::csr_data_t  o_trap_address,         // mtvec
    output csr_pkg::csr_data_t  o_return_address,       // mepc
    output logic                o_go_to_trap_q,
    output logic                o_return_from_trap_q
);

    import csr_pkg::*;

    logic       wr_en;          // Also the CSR read strobe
    csr_data_t  wr_data;
    csr_data_t  rd_data;
    logic       take_trap;
    logic       take_return;
    csr_cause_e cause_code;
    logic       cause_int;
    logic       mstatus_mie;
    logic       mie_meie;
    logic       mie_msie;
    logic       mip_meip;
    logic       mip_msip;

    csr_write_value u_write_value (
        .i_stage_en  (i_stage_en),
        .i_is_system (i_is_system),
        .i_funct3    (i_funct3),
        .i_rs1       (i_rs1),
        .i_imm       (i_imm),
        .i_rd_data   (rd_data),
        .o_wr_en     (wr_en),
        .o_wr_data   (wr_data)
    );

    csr_trap_ctrl u_trap_ctrl (
        .i_clk                (i_clk),
        .i_rst_n              (i_rst_n),
        .i_stage_en           (i_stage_en),
        .i_is_illegal         (i_is_illegal),
        .i_is_ecall           (i_is_ecall),
        .i_is_ebreak          (i_is_ebreak),
        .i_is_mret            (i_is_mret),
        .i_mstatus_mie        (mstatus_mie),
        .i_mie_meie           (mie_meie),
        .i_mie_msie           (mie_msie),
        .i_mip_meip           (mip_meip),
        .i_mip_msip           (mip_msip),
        .o_take_trap          (take_trap),
        .o_take_return        (take_return),
        .o_cause_code         (cause_code),
        .o_cause_int          (cause_int),
        .o_go_to_trap_q       (o_go_to_trap_q),
        .o_return_from_trap_q (o_return_from_trap_q)
    );

    csr_regfile u_regfile (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_csr_index   (i_csr_index),
        .i_wr_en       (wr_en),
        .i_wr_data     (wr_data),
        .i_take_trap   (take_trap),
        .i_take_return (take_return),
        .i_cause_code  (cause_code),
        .i_cause_int   (cause_int),
        .i_pc          (i_pc),
        .i_ext_irq     (i_ext_irq),
        .i_sw_irq      (i_sw_irq),
        .o_rd_data     (rd_data),
        .o_mtvec       (o_trap_address),
        .o_mepc        (o_return_address),
        .o_mstatus_mie (mstatus_mie),
        .o_mie_meie    (mie_meie),
        .o_mie_msie    (mie_msie),
        .o_mip_meip    (mip_meip),
        .o_mip_msip    (mip_msip)
    );

    // Captures the pre-write value, held until the next CSR instruction
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_csr_out <= '0;
        end else if (wr_en) begin
            o_csr_out <= rd_data;
        end
    end

endmodule

// File: source/csr_regfile.sv
`timescale 1ns/1ps

`include "csr_config.svh"

module csr_regfile (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  csr_pkg::csr_addr_e  i_csr_index,    // Addressed CSR
    input  logic                i_wr_en,        // CSR instruction write strobe
    input  csr_pkg::csr_data_t  i_wr_data,      // New value
    input  logic                i_take_trap,    // Trap entry this cycle
    input  logic                i_take_return,  // mret this cycle
    input  csr_pkg::csr_cause_e i_cause_code,
    input  logic                i_cause_int,
    input  csr_pkg::csr_data_t  i_pc,           // pc of current instruction
    input  logic                i_ext_irq,      // Raw external interrupt level
    input  logic                i_sw_irq,       // Raw software interrupt level
    output csr_pkg::csr_data_t  o_rd_data,      // Combinational read data
    output csr_pkg::csr_data_t  o_mtvec,
    output csr_pkg::csr_data_t  o_mepc,
    output logic                o_mstatus_mie,
    output logic                o_mie_meie,
    output logic                o_mie_msie,
    output logic                o_mip_meip,
    output logic                o_mip_msip
);

    import csr_pkg::*;

    localparam int HI = `CSR_COUNTER_WIDTH - 1;    // Top bit of mcycle
    localparam int LO = `CSR_XLEN;                 // First bit of mcycleh

    logic                           mstatus_mie;
    logic                           mstatus_mpie;
    logic                           mie_meie;
    logic                           mie_msie;
    csr_data_t                      mtvec;
    csr_data_t                      mscratch;
    csr_data_t                      mepc;
    logic                           mcause_int;
    csr_cause_e                     mcause_code;
    logic                           mip_meip;
    logic                           mip_msip;
    logic [`CSR_COUNTER_WIDTH-1:0]  mcycle;
    logic                           mcountinhibit_cy;

    // Per-register write selects
    logic wr_mstatus, wr_mie, wr_mtvec, wr_mscratch, wr_mepc;
    logic wr_mcause, wr_mcycle, wr_mcycleh, wr_mcountinhibit;

    assign wr_mstatus       = i_wr_en && (i_csr_index == ADDR_MSTATUS);
    assign wr_mie           = i_wr_en && (i_csr_index == ADDR_MIE);
    assign wr_mtvec         = i_wr_en && (i_csr_index == ADDR_MTVEC);
    assign wr_mscratch      = i_wr_en && (i_csr_index == ADDR_MSCRATCH);
    assign wr_mepc          = i_wr_en && (i_csr_index == ADDR_MEPC);
    assign wr_mcause        = i_wr_en && (i_csr_index == ADDR_MCAUSE);
    assign wr_mcycle        = i_wr_en && (i_csr_index == ADDR_MCYCLE);
    assign wr_mcycleh       = i_wr_en && (i_csr_index == ADDR_MCYCLEH);
    assign wr_mcountinhibit = i_wr_en && (i_csr_index == ADDR_MCOUNTINHIBIT);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mstatus_mie      <= 1'b0;
            mstatus_mpie     <= 1'b0;
            mie_meie         <= 1'b0;
            mie_msie         <= 1'b0;
            mtvec            <= `CSR_TRAP_VECTOR;
            mscratch         <= '0;
            mepc             <= '0;
            mcause_int       <= 1'b0;
            mcause_code      <= '0;
            mip_meip         <= 1'b0;
            mip_msip         <= 1'b0;
            mcycle           <= '0;
            mcountinhibit_cy <= 1'b0;
        end else begin
            // Software write beats the trap/return stack
            if (wr_mstatus) begin
                mstatus_mie  <= i_wr_data[3];
                mstatus_mpie <= i_wr_data[7];
            end else if (i_take_trap) begin
                mstatus_mie  <= 1'b0;
                mstatus_mpie <= mstatus_mie;        // Save enable
            end else if (i_take_return) begin
                mstatus_mie  <= mstatus_mpie;       // Restore enable
                mstatus_mpie <= 1'b1;
            end

            if (wr_mie) begin
                mie_meie <= i_wr_data[11];
                mie_msie <= i_wr_data[3];
            end

            if (wr_mtvec) begin
                mtvec <= i_wr_data;
            end

            if (wr_mscratch) begin
                mscratch <= i_wr_data;
            end

            // Trap beats a write on mepc and mcause
            if (i_take_trap) begin
                mepc <= i_pc;
            end else if (wr_mepc) begin
                mepc <= {i_wr_data[`CSR_XLEN-1:2], 2'b00};     // Word aligned
            end

            if (i_take_trap) begin
                mcause_int  <= i_cause_int;
                mcause_code <= i_cause_code;
            end else if (wr_mcause) begin
                mcause_int  <= i_wr_data[`CSR_XLEN-1];
                mcause_code <= i_wr_data[3:0];
            end

            mip_meip <= i_ext_irq;      // One cycle of sync delay
            mip_msip <= i_sw_irq;

            // Written half holds the data, no increment that cycle
            if (wr_mcycle) begin
                mcycle[LO-1:0] <= i_wr_data;
            end else if (wr_mcycleh) begin
                mcycle[HI:LO] <= i_wr_data;
            end else if (!mcountinhibit_cy) begin
                mcycle <= mcycle + 1'b1;
            end

            if (wr_mcountinhibit) begin
                mcountinhibit_cy <= i_wr_data[0];
            end
        end
    end

    // Read mux, unlisted addresses and ID registers give zero
    always_comb begin
        o_rd_data = '0;
        case (i_csr_index)
            ADDR_MSTATUS: begin
                o_rd_data[3]     = mstatus_mie;
                o_rd_data[7]     = mstatus_mpie;
                o_rd_data[12:11] = 2'b11;           // M-mode only
            end
            ADDR_MISA: begin
                o_rd_data[8]     = 1'b1;            // I base
                o_rd_data[31:30] = 2'b01;           // MXL 32
            end
            ADDR_MIE: begin
                o_rd_data[3]  = mie_msie;
                o_rd_data[11] = mie_meie;
            end
            ADDR_MIP: begin
                o_rd_data[3]  = mip_msip;
                o_rd_data[11] = mip_meip;
            end
            ADDR_MCAUSE: begin
                o_rd_data[`CSR_XLEN-1] = mcause_int;
                o_rd_data[3:0]         = mcause_code;
            end
            ADDR_MTVEC:         o_rd_data = mtvec;
            ADDR_MSCRATCH:      o_rd_data = mscratch;
            ADDR_MEPC:          o_rd_data = mepc;
            ADDR_MCYCLE:        o_rd_data = mcycle[LO-1:0];
            ADDR_MCYCLEH:       o_rd_data = mcycle[HI:LO];
            ADDR_MCOUNTINHIBIT: o_rd_data[0] = mcountinhibit_cy;
            default:            o_rd_data = '0;
        endcase
    end

    assign o_mtvec       = mtvec;
    assign o_mepc        = mepc;
    assign o_mstatus_mie = mstatus_mie;
    assign o_mie_meie    = mie_meie;
    assign o_mie_msie    = mie_msie;
    assign o_mip_meip    = mip_meip;
    assign o_mip_msip    = mip_msip;

endmodule

// File: source/csr_trap_ctrl.sv
`timescale 1ns/1ps

module csr_trap_ctrl (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_stage_en,             // Instruction sits in CSR stage
    input  logic                i_is_illegal,           // Illegal instruction
    input  logic                i_is_ecall,             // ECALL
    input  logic                i_is_ebreak,            // EBREAK
    input  logic                i_is_mret,              // MRET
    input  logic                i_mstatus_mie,          // Global interrupt enable
    input  logic                i_mie_meie,             // External enable
    input  logic                i_mie_msie,             // Software enable
    input  logic                i_mip_meip,             // External pending
    input  logic                i_mip_msip,             // Software pending
    output logic                o_take_trap,            // Trap this cycle
    output logic                o_take_return,          // Return this cycle
    output csr_pkg::csr_cause_e o_cause_code,           // mcause code
    output logic                o_cause_int,            // mcause interrupt bit
    output logic                o_go_to_trap_q,         // Pulse after trap decision
    output logic                o_return_from_trap_q    // Pulse after return decision
);

    import csr_pkg::*;

    logic ext_irq;      // Enabled external interrupt
    logic sw_irq;       // Enabled software interrupt
    logic irq_any;
    logic exc_any;

    assign ext_irq = i_mstatus_mie && i_mie_meie && i_mip_meip;
    assign sw_irq  = i_mstatus_mie && i_mie_msie && i_mip_msip;
    assign irq_any = ext_irq || sw_irq;
    assign exc_any = i_is_illegal || i_is_ecall || i_is_ebreak;

    assign o_take_trap   = i_stage_en && (irq_any || exc_any);
    assign o_take_return = i_stage_en && i_is_mret && !o_take_trap;   // Trap wins over mret

    // Interrupts first, then synchronous exceptions
    always_comb begin
        o_cause_code = '0;
        o_cause_int  = 1'b0;
        if (ext_irq) begin
            o_cause_code = CAUSE_EXT_IRQ;
            o_cause_int  = 1'b1;
        end else if (sw_irq) begin
            o_cause_code = CAUSE_SW_IRQ;
            o_cause_int  = 1'b1;
        end else if (i_is_illegal) begin
            o_cause_code = CAUSE_ILLEGAL;
        end else if (i_is_ecall) begin
            o_cause_code = CAUSE_ECALL;
        end else if (i_is_ebreak) begin
            o_cause_code = CAUSE_EBREAK;
        end
    end

    // One clock behind the decision, same edge as the CSR updates
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_go_to_trap_q       <= 1'b0;
            o_return_from_trap_q <= 1'b0;
        end else begin
            o_go_to_trap_q       <= o_take_trap;
            o_return_from_trap_q <= o_take_return;
        end
    end

endmodule

// File: source/csr_write_value.sv
`timescale 1ns/1ps

module csr_write_value (
    input  logic                i_stage_en,     // Instruction sits in CSR stage
    input  logic                i_is_system,    // SYSTEM opcode
    input  csr_pkg::csr_op_e    i_funct3,       // CSR operation
    input  csr_pkg::csr_data_t  i_rs1,          // Register source
    input  csr_pkg::csr_data_t  i_imm,          // Zero-extended uimm source
    input  csr_pkg::csr_data_t  i_rd_data,      // Current value of addressed CSR
    output logic                o_wr_en,        // Write strobe to register file
    output csr_pkg::csr_data_t  o_wr_data       // Read-modify-write result
);

    import csr_pkg::*;

    csr_data_t src;     // Operand after rs1/imm select

    // Only gate for a CSR write anywhere in the design
    assign o_wr_en = i_stage_en && i_is_system && (i_funct3 != CSR_NONE);

    // funct3[2] marks the immediate forms
    always_comb begin
        if (i_funct3[2]) begin
            src = i_imm;
        end else begin
            src = i_rs1;
        end
    end

    always_comb begin
        case (i_funct3)
            CSRRW, CSRRWI: begin
                o_wr_data = src;                    // Replace
            end
            CSRRS, CSRRSI: begin
                o_wr_data = i_rd_data | src;        // Set bits
            end
            CSRRC, CSRRCI: begin
                o_wr_data = i_rd_data & ~src;       // Clear bits
            end
            default: begin
                o_wr_data = i_rd_data;              // No change, strobe low anyway
            end
        endcase
    end

endmodule

// File: source/csr_pkg.sv
`include "csr_config.svh"

package csr_pkg;

    typedef logic [`CSR_XLEN-1:0] csr_data_t;   // One CSR-wide word

    // Kept machine-mode CSR addresses
    typedef enum logic [11:0] {
        ADDR_MVENDORID     = 12'hF11,   // Vendor ID, reads zero
        ADDR_MARCHID       = 12'hF12,   // Architecture ID, reads zero
        ADDR_MIMPID        = 12'hF13,   // Implementation ID, reads zero
        ADDR_MHARTID       = 12'hF14,   // Hart ID, reads zero
        ADDR_MSTATUS       = 12'h300,   // Status
        ADDR_MISA          = 12'h301,   // ISA and extensions
        ADDR_MIE           = 12'h304,   // Interrupt enables
        ADDR_MTVEC         = 12'h305,   // Trap vector
        ADDR_MCOUNTINHIBIT = 12'h320,   // Counter inhibit
        ADDR_MSCRATCH      = 12'h340,   // Scratch
        ADDR_MEPC          = 12'h341,   // Exception pc
        ADDR_MCAUSE        = 12'h342,   // Trap cause
        ADDR_MIP           = 12'h344,   // Interrupts pending
        ADDR_MCYCLE        = 12'hB00,   // Cycle counter, low half
        ADDR_MCYCLEH       = 12'hB80    // Cycle counter, high half
    } csr_addr_e;

    // funct3 of the SYSTEM opcode
    typedef enum logic [2:0] {
        CSR_NONE = 3'b000,  // Not a CSR instruction
        CSRRW    = 3'b001,
        CSRRS    = 3'b010,
        CSRRC    = 3'b011,
        CSRRWI   = 3'b101,
        CSRRSI   = 3'b110,
        CSRRCI   = 3'b111
    } csr_op_e;

    // Interrupt and exception codes overlap, so plain values
    typedef logic [3:0] csr_cause_e;

    localparam csr_cause_e CAUSE_EXT_IRQ = 4'd11;   // Interrupt bit set
    localparam csr_cause_e CAUSE_SW_IRQ  = 4'd3;    // Interrupt bit set
    localparam csr_cause_e CAUSE_ILLEGAL = 4'd2;
    localparam csr_cause_e CAUSE_ECALL   = 4'd11;
    localparam csr_cause_e CAUSE_EBREAK  = 4'd3;

endpackage

// File: source/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Width of CSR data, rs1, imm and pc
`define CSR_XLEN 32

// mtvec value after reset (base in [31:2], mode in [1:0])
`define CSR_TRAP_VECTOR 32'h0000_0100

// Full width of mcycle, read as two CSR_XLEN halves
`define CSR_COUNTER_WIDTH 64

`endif
